//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - source/icache_geom_pkg.sv
      - source/fetch_bus_pkg.sv
      - source/icache_tag_array.sv
      - source/icache_data_array.sv
      - source/icache_victim_select.sv
      - source/icache_refill_ctrl.sv
      - source/icache.sv
  - target: simulation
    files:
      - verif/icache_assertions.sv
      - verif/icache_tb.sv

//--- files.f
source/icache_geom_pkg.sv
source/fetch_bus_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_victim_select.sv
source/icache_refill_ctrl.sv
source/icache.sv
verif/icache_assertions.sv
verif/icache_tb.sv

//--- source/fetch_bus_pkg.sv
`default_nettype none

package fetch_bus_pkg;

    // Fetch and memory bus widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // One fetch address, seen as a raw word or split into cache fields.
    // Field order runs from the MSB down to the byte offset.
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [icache_geom_pkg::TAG_W-1:0]   tag;
            logic [icache_geom_pkg::INDEX_W-1:0] index;
            logic [icache_geom_pkg::WOFS_W-1:0]  wofs;
            logic [icache_geom_pkg::BYTE_W-1:0]  byte_ofs;
        } f;
    } fetch_addr_t;

endpackage

`default_nettype wire

//--- source/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic                                  Clk,
    input  logic                                  arst_n,

    // Fetch side
    input  logic                                  ReadEnable,
    input  logic [fetch_bus_pkg::ADDR_W-1:0]      ReadAddress,
    output logic [fetch_bus_pkg::WORD_W-1:0]      Instruction,
    output logic                                  Ready,
    output logic                                  Busy,

    // Memory side
    output logic [fetch_bus_pkg::ADDR_W-1:0]      MemReadAddress,
    output logic                                  MemReadRequest,
    input  logic [fetch_bus_pkg::WORD_W-1:0]      MemDataIn,
    input  logic                                  MemDataReady,

    // Pipeline control
    input  logic                                  Mispredict,
    input  logic                                  Flush
);

    logic                                 lookup_en;
    logic                                 hit;
    logic [icache_geom_pkg::WAY_W-1:0]    hit_way;
    logic [icache_geom_pkg::NUM_WAYS-1:0] valid_vec;
    logic [icache_geom_pkg::INDEX_W-1:0]  lookup_index;
    logic [icache_geom_pkg::WAY_W-1:0]    victim_way;

    logic                                 rd_en;
    logic [icache_geom_pkg::WOFS_W-1:0]   rd_wofs;
    logic [fetch_bus_pkg::WORD_W-1:0]     rd_word;

    logic                                 fill_en;
    logic [icache_geom_pkg::INDEX_W-1:0]  fill_index;
    logic [icache_geom_pkg::WAY_W-1:0]    fill_way;
    logic [icache_geom_pkg::TAG_W-1:0]    fill_tag;
    logic [icache_geom_pkg::BLOCK_WORDS-1:0][fetch_bus_pkg::WORD_W-1:0] fill_block;
    logic                                 fill_set_full;

    icache_tag_array u_tag_array (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .lookup_en    (lookup_en),
        .lookup_addr  (ReadAddress),
        .fill_en      (fill_en),
        .fill_index   (fill_index),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .valid_vec    (valid_vec),
        .lookup_index (lookup_index)
    );

    // Word read uses the way found by the tag lookup
    icache_data_array u_data_array (
        .Clk        (Clk),
        .rd_en      (rd_en),
        .rd_index   (lookup_index),
        .rd_way     (hit_way),
        .rd_wofs    (rd_wofs),
        .rd_word    (rd_word),
        .fill_en    (fill_en),
        .fill_index (fill_index),
        .fill_way   (fill_way),
        .fill_block (fill_block)
    );

    icache_victim_select u_victim_select (
        .Clk           (Clk),
        .arst_n        (arst_n),
        .index         (lookup_index),
        .valid_vec     (valid_vec),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_set_full (fill_set_full),
        .victim_way    (victim_way)
    );

    icache_refill_ctrl u_refill_ctrl (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .ReadEnable     (ReadEnable),
        .ReadAddress    (ReadAddress),
        .Instruction    (Instruction),
        .Ready          (Ready),
        .Busy           (Busy),
        .Flush          (Flush),
        .Mispredict     (Mispredict),
        .MemReadAddress (MemReadAddress),
        .MemReadRequest (MemReadRequest),
        .MemDataIn      (MemDataIn),
        .MemDataReady   (MemDataReady),
        .hit            (hit),
        .victim_way     (victim_way),
        .valid_vec      (valid_vec),
        .rd_word        (rd_word),
        .lookup_en      (lookup_en),
        .rd_en          (rd_en),
        .rd_wofs        (rd_wofs),
        .fill_en        (fill_en),
        .fill_index     (fill_index),
        .fill_way       (fill_way),
        .fill_tag       (fill_tag),
        .fill_block     (fill_block),
        .fill_set_full  (fill_set_full)
    );

endmodule

`default_nettype wire

//--- source/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
    input  logic                                  Clk,

    // Word read port
    input  logic                                  rd_en,
    input  logic [icache_geom_pkg::INDEX_W-1:0]   rd_index,
    input  logic [icache_geom_pkg::WAY_W-1:0]     rd_way,
    input  logic [icache_geom_pkg::WOFS_W-1:0]    rd_wofs,
    output logic [fetch_bus_pkg::WORD_W-1:0]      rd_word,

    // Whole-block write port
    input  logic                                  fill_en,
    input  logic [icache_geom_pkg::INDEX_W-1:0]   fill_index,
    input  logic [icache_geom_pkg::WAY_W-1:0]     fill_way,
    input  logic [icache_geom_pkg::BLOCK_WORDS-1:0][fetch_bus_pkg::WORD_W-1:0] fill_block
);

    logic [fetch_bus_pkg::WORD_W-1:0] mem_q
        [icache_geom_pkg::NUM_SETS][icache_geom_pkg::NUM_WAYS][icache_geom_pkg::BLOCK_WORDS];

    // Read word is held until the next read
    always_ff @(posedge Clk) begin
        if (rd_en) begin
            rd_word <= mem_q[rd_index][rd_way][rd_wofs];
        end
    end

    // All words of a block land together
    always_ff @(posedge Clk) begin
        if (fill_en) begin
            for (int w = 0; w < icache_geom_pkg::BLOCK_WORDS; w++) begin
                mem_q[fill_index][fill_way][w] <= fill_block[w];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/icache_geom_pkg.sv
`default_nettype none

package icache_geom_pkg;

    // Cache organisation
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;

    // Field widths within a 32-bit byte address
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int WAY_W   = $clog2(NUM_WAYS);
    localparam int WOFS_W  = $clog2(BLOCK_WORDS);
    localparam int BYTE_W  = 2;

    // Whatever is left above the index forms the tag
    localparam int TAG_W = 32 - INDEX_W - WOFS_W - BYTE_W;

endpackage

`default_nettype wire

//--- source/icache_refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl (
    input  logic                                  Clk,
    input  logic                                  arst_n,

    // Fetch side
    input  logic                                  ReadEnable,
    input  logic [fetch_bus_pkg::ADDR_W-1:0]      ReadAddress,
    output logic [fetch_bus_pkg::WORD_W-1:0]      Instruction,
    output logic                                  Ready,
    output logic                                  Busy,
    input  logic                                  Flush,
    input  logic                                  Mispredict,

    // Memory side
    output logic [fetch_bus_pkg::ADDR_W-1:0]      MemReadAddress,
    output logic                                  MemReadRequest,
    input  logic [fetch_bus_pkg::WORD_W-1:0]      MemDataIn,
    input  logic                                  MemDataReady,

    // Array and victim interface
    input  logic                                  hit,
    input  logic [icache_geom_pkg::WAY_W-1:0]     victim_way,
    input  logic [icache_geom_pkg::NUM_WAYS-1:0]  valid_vec,
    input  logic [fetch_bus_pkg::WORD_W-1:0]      rd_word,
    output logic                                  lookup_en,
    output logic                                  rd_en,
    output logic [icache_geom_pkg::WOFS_W-1:0]    rd_wofs,
    output logic                                  fill_en,
    output logic [icache_geom_pkg::INDEX_W-1:0]   fill_index,
    output logic [icache_geom_pkg::WAY_W-1:0]     fill_way,
    output logic [icache_geom_pkg::TAG_W-1:0]     fill_tag,
    output logic [icache_geom_pkg::BLOCK_WORDS-1:0][fetch_bus_pkg::WORD_W-1:0] fill_block,
    output logic                                  fill_set_full
);

    // Idle is neither flag set
    logic lookup_q;
    logic refill_q;
    logic from_hit_q;

    fetch_bus_pkg::fetch_addr_t           req_addr;
    fetch_bus_pkg::fetch_addr_t           block_addr;
    logic [icache_geom_pkg::WAY_W-1:0]    victim_q;
    logic                                 set_full_q;
    logic [icache_geom_pkg::WOFS_W-1:0]   beat_cnt;
    logic [icache_geom_pkg::BLOCK_WORDS-1:0][fetch_bus_pkg::WORD_W-1:0] beat_buf;
    logic [fetch_bus_pkg::WORD_W-1:0]     fill_word_q;

    logic miss;
    logic beat;
    logic last_beat;

    // A new read is taken only when fully idle, Ready cycle included
    assign lookup_en = ReadEnable && !lookup_q && !refill_q && !Ready && !Flush;
    assign rd_en     = lookup_q && hit && !Flush;
    assign miss      = lookup_q && !hit && !Flush;

    // Accepted beat; Mispredict on a beat throws the refill away
    assign beat      = refill_q && MemDataReady && !Flush && !Mispredict;
    assign last_beat = beat && (int'(beat_cnt) == icache_geom_pkg::BLOCK_WORDS - 1);

    always_comb begin
        block_addr            = req_addr;
        block_addr.f.wofs     = '0;
        block_addr.f.byte_ofs = '0;
    end

    // Last word goes straight from the bus into the block
    always_comb begin
        for (int w = 0; w < icache_geom_pkg::BLOCK_WORDS; w++) begin
            fill_block[w] = (w == int'(beat_cnt)) ? MemDataIn : beat_buf[w];
        end
    end

    assign fill_en       = last_beat;
    assign fill_index    = req_addr.f.index;
    assign fill_tag      = req_addr.f.tag;
    assign fill_way      = victim_q;
    assign fill_set_full = set_full_q;
    assign rd_wofs       = req_addr.f.wofs;

    assign Instruction = from_hit_q ? rd_word : fill_word_q;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_q       <= 1'b0;
            refill_q       <= 1'b0;
            from_hit_q     <= 1'b0;
            Ready          <= 1'b0;
            Busy           <= 1'b0;
            MemReadRequest <= 1'b0;
            beat_cnt       <= '0;
        end else begin
            Ready <= 1'b0;
            if (Flush) begin
                // Flush kills whatever is in flight
                lookup_q       <= 1'b0;
                refill_q       <= 1'b0;
                Busy           <= 1'b0;
                MemReadRequest <= 1'b0;
                beat_cnt       <= '0;
            end else begin
                if (lookup_en) begin
                    lookup_q <= 1'b1;
                end
                if (lookup_q) begin
                    lookup_q <= 1'b0;
                    if (hit) begin
                        Ready      <= 1'b1;
                        from_hit_q <= 1'b1;
                    end else begin
                        refill_q       <= 1'b1;
                        Busy           <= 1'b1;
                        MemReadRequest <= 1'b1;
                        beat_cnt       <= '0;
                    end
                end
                if (refill_q && MemDataReady) begin
                    if (Mispredict) begin
                        refill_q       <= 1'b0;
                        Busy           <= 1'b0;
                        MemReadRequest <= 1'b0;
                        beat_cnt       <= '0;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            refill_q       <= 1'b0;
                            Busy           <= 1'b0;
                            MemReadRequest <= 1'b0;
                            Ready          <= 1'b1;
                            from_hit_q     <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // Address, victim and beat data
    always_ff @(posedge Clk) begin
        if (lookup_en) begin
            req_addr.raw <= ReadAddress;
        end
        if (miss) begin
            victim_q       <= victim_way;
            set_full_q     <= &valid_vec;
            MemReadAddress <= block_addr.raw;
        end
        if (beat) begin
            beat_buf[beat_cnt] <= MemDataIn;
        end
        if (last_beat) begin
            fill_word_q <= fill_block[req_addr.f.wofs];
        end
    end

endmodule

`default_nettype wire

//--- source/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
    input  logic                                  Clk,
    input  logic                                  arst_n,

    // Lookup port
    input  logic                                  lookup_en,
    input  fetch_bus_pkg::fetch_addr_t            lookup_addr,

    // Fill port
    input  logic                                  fill_en,
    input  logic [icache_geom_pkg::INDEX_W-1:0]   fill_index,
    input  logic [icache_geom_pkg::WAY_W-1:0]     fill_way,
    input  logic [icache_geom_pkg::TAG_W-1:0]     fill_tag,

    // Registered lookup result
    output logic                                  hit,
    output logic [icache_geom_pkg::WAY_W-1:0]     hit_way,
    output logic [icache_geom_pkg::NUM_WAYS-1:0]  valid_vec,
    output logic [icache_geom_pkg::INDEX_W-1:0]   lookup_index
);

    logic [icache_geom_pkg::NUM_WAYS-1:0] valid_q [icache_geom_pkg::NUM_SETS];
    logic [icache_geom_pkg::TAG_W-1:0]
        tag_q [icache_geom_pkg::NUM_SETS][icache_geom_pkg::NUM_WAYS];

    logic                                 any_match;
    logic [icache_geom_pkg::WAY_W-1:0]    match_way;
    logic [icache_geom_pkg::INDEX_W-1:0]  set_idx;

    assign set_idx = lookup_addr.f.index;

    // Compare every way of the addressed set at once
    always_comb begin
        any_match = 1'b0;
        match_way = '0;
        for (int w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin
            if (valid_q[set_idx][w] && (tag_q[set_idx][w] == lookup_addr.f.tag)) begin
                any_match = 1'b1;
                match_way = w[icache_geom_pkg::WAY_W-1:0];
            end
        end
    end

    // Valid bits and the hit strobe
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hit <= 1'b0;
            for (int s = 0; s < icache_geom_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            hit <= lookup_en && any_match;
            if (fill_en) begin
                valid_q[fill_index][fill_way] <= 1'b1;
            end
        end
    end

    // Tags and the rest of the lookup result
    always_ff @(posedge Clk) begin
        if (lookup_en) begin
            hit_way      <= match_way;
            valid_vec    <= valid_q[set_idx];
            lookup_index <= set_idx;
        end
        if (fill_en) begin
            tag_q[fill_index][fill_way] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

//--- source/icache_victim_select.sv
`timescale 1ns/1ps
`default_nettype none

module icache_victim_select (
    input  logic                                  Clk,
    input  logic                                  arst_n,

    // Set under lookup and its valid bits
    input  logic [icache_geom_pkg::INDEX_W-1:0]   index,
    input  logic [icache_geom_pkg::NUM_WAYS-1:0]  valid_vec,

    // Fill notification
    input  logic                                  fill_en,
    input  logic [icache_geom_pkg::INDEX_W-1:0]   fill_index,
    input  logic                                  fill_set_full,

    output logic [icache_geom_pkg::WAY_W-1:0]     victim_way
);

    logic [icache_geom_pkg::WAY_W-1:0] rr_ptr [icache_geom_pkg::NUM_SETS];
    logic                              found;

    // Lowest invalid way wins, else the set's pointer
    always_comb begin
        found      = 1'b0;
        victim_way = rr_ptr[index];
        for (int w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin
            if (!found && !valid_vec[w]) begin
                found      = 1'b1;
                victim_way = w[icache_geom_pkg::WAY_W-1:0];
            end
        end
    end

    // Pointer wraps naturally since NUM_WAYS is a power of two
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < icache_geom_pkg::NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (fill_en && fill_set_full) begin
            rr_ptr[fill_index] <= rr_ptr[fill_index] + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verif/icache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module icache_assertions (
    input  logic                                  Clk,
    input  logic                                  arst_n,
    input  logic [fetch_bus_pkg::ADDR_W-1:0]      MemReadAddress,
    input  logic                                  MemReadRequest,
    input  logic                                  MemDataReady,
    input  logic                                  Mispredict,
    input  logic                                  Flush,
    input  logic                                  Ready,
    input  logic                                  Busy,
    input  logic                                  fill_en
);

    // Number of failed assertions, read by the testbench at the end
    int fail_count = 0;

    // Request address points at word 0 of a block
    a_req_aligned: assert property (@(posedge Clk) disable iff (!arst_n)
        MemReadRequest |->
            (MemReadAddress[icache_geom_pkg::WOFS_W+icache_geom_pkg::BYTE_W-1:0] == '0))
        else begin
            fail_count++;
            $error("MemReadAddress not block aligned during a request");
        end

    // Request and address hold until the block completes or a cancel
    a_req_hold: assert property (@(posedge Clk) disable iff (!arst_n)
        (MemReadRequest && !fill_en && !Flush && !(Mispredict && MemDataReady))
            |=> (MemReadRequest && $stable(MemReadAddress)))
        else begin
            fail_count++;
            $error("MemReadRequest or MemReadAddress changed before the refill ended");
        end

    a_ready_not_busy: assert property (@(posedge Clk) disable iff (!arst_n)
        !(Ready && Busy))
        else begin
            fail_count++;
            $error("Ready and Busy high in the same cycle");
        end

    // Strobes stay low through reset and on the first edge after it
    a_reset_low: assert property (@(posedge Clk)
        (!arst_n || $rose(arst_n)) |-> (!Ready && !Busy && !MemReadRequest))
        else begin
            fail_count++;
            $error("Output strobe high during or right after reset");
        end

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 24;
    localparam int NUM_FETCHES  = NUM_RANDOM + NUM_DIRECTED;

    // Worst case per fetch is a lookup plus four beats with the longest gap
    localparam int TIMEOUT_CYCLES =
        NUM_FETCHES * (2 + icache_geom_pkg::BLOCK_WORDS * 4) + NUM_FETCHES + 200;

    localparam int CANCEL_NONE       = 0;
    localparam int CANCEL_FLUSH      = 1;
    localparam int CANCEL_MISPREDICT = 2;

    localparam int OFS_BITS   = icache_geom_pkg::WOFS_W + icache_geom_pkg::BYTE_W;
    localparam int BLOCK_SIZE = icache_geom_pkg::BLOCK_WORDS * 4;
    localparam int SET_STRIDE = icache_geom_pkg::NUM_SETS * BLOCK_SIZE;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                              Clk;
    logic                              arst_n;
    logic                              ReadEnable;
    logic [fetch_bus_pkg::ADDR_W-1:0]  ReadAddress;
    logic [fetch_bus_pkg::WORD_W-1:0]  Instruction;
    logic                              Ready;
    logic                              Busy;
    logic [fetch_bus_pkg::ADDR_W-1:0]  MemReadAddress;
    logic                              MemReadRequest;
    logic [fetch_bus_pkg::WORD_W-1:0]  MemDataIn;
    logic                              MemDataReady;
    logic                              Mispredict;
    logic                              Flush;

    logic [31:0] lfsr_q;
    int          error_count;
    int          fetch_count;
    logic [31:0] expected_q [$];

    // Software copy of the cache directory
    bit          ref_valid [icache_geom_pkg::NUM_SETS][icache_geom_pkg::NUM_WAYS];
    logic [31:0] ref_tag   [icache_geom_pkg::NUM_SETS][icache_geom_pkg::NUM_WAYS];
    int          ref_ptr   [icache_geom_pkg::NUM_SETS];

    // Block order for the conflict re-reads
    int reread_order [8] = '{1, 2, 3, 4, 0, 1, 3, 2};

    icache UUT (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .ReadEnable     (ReadEnable),
        .ReadAddress    (ReadAddress),
        .Instruction    (Instruction),
        .Ready          (Ready),
        .Busy           (Busy),
        .MemReadAddress (MemReadAddress),
        .MemReadRequest (MemReadRequest),
        .MemDataIn      (MemDataIn),
        .MemDataReady   (MemDataReady),
        .Mispredict     (Mispredict),
        .Flush          (Flush)
    );

    bind icache icache_assertions u_assertions (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .MemReadAddress (MemReadAddress),
        .MemReadRequest (MemReadRequest),
        .MemDataReady   (MemDataReady),
        .Mispredict     (Mispredict),
        .Flush          (Flush),
        .Ready          (Ready),
        .Busy           (Busy),
        .fill_en        (fill_en)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    // Memory contents, a scramble of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [29:0] w;
        w = addr[31:2];
        return ({2'b00, w} * 32'h9e37_79b1) ^ {w[13:0], w[29:12]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic int addr_set(input logic [31:0] addr);
        return int'((addr >> OFS_BITS) % icache_geom_pkg::NUM_SETS);
    endfunction

    function automatic logic [31:0] addr_tag(input logic [31:0] addr);
        return addr >> (OFS_BITS + icache_geom_pkg::INDEX_W);
    endfunction

    // Expected hit or miss from the software directory
    function automatic bit ref_hit(input logic [31:0] addr);
        int s;
        bit found;
        s     = addr_set(addr);
        found = 1'b0;
        for (int w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin
            if (ref_valid[s][w] && (ref_tag[s][w] == addr_tag(addr))) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Lowest invalid way, else the round-robin pointer which then moves on
    function automatic void ref_fill(input logic [31:0] addr);
        int s;
        int way;
        s   = addr_set(addr);
        way = -1;
        for (int w = icache_geom_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!ref_valid[s][w]) begin
                way = w;
            end
        end
        if (way < 0) begin
            way        = ref_ptr[s];
            ref_ptr[s] = (ref_ptr[s] + 1) % icache_geom_pkg::NUM_WAYS;
        end
        ref_valid[s][way] = 1'b1;
        ref_tag[s][way]   = addr_tag(addr);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        error_count++;
        $display("FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
    endtask

    task automatic next_cycle();
        @(posedge Clk);
        #1;
    endtask

    // One fetch, with the memory side served inline
    task automatic run_fetch(input logic [31:0] addr, input int cancel_kind,
                             input int cancel_beat);
        bit          exp_hit;
        bit          cancelled;
        int          gap;
        logic [31:0] blk;
        exp_hit   = ref_hit(addr);
        cancelled = 1'b0;
        blk       = addr & ~(BLOCK_SIZE - 1);
        if (exp_hit || cancel_kind == CANCEL_NONE) begin
            expected_q.push_back(mem_word(addr));
        end
        fetch_count++;
        ReadEnable  = 1'b1;
        ReadAddress = addr;
        next_cycle();
        next_cycle();
        if (MemReadRequest !== !exp_hit) begin
            report_mismatch("MemReadRequest", {31'b0, !exp_hit}, {31'b0, MemReadRequest});
        end
        if (MemReadRequest === 1'b1) begin
            if (MemReadAddress !== blk) begin
                report_mismatch("MemReadAddress", blk, MemReadAddress);
            end
            if (Busy !== 1'b1) begin
                report_mismatch("Busy", 32'h1, {31'b0, Busy});
            end
            for (int b = 0; b < icache_geom_pkg::BLOCK_WORDS && !cancelled; b++) begin
                gap = int'(take_bits(2));
                if (cancel_kind == CANCEL_FLUSH && b == cancel_beat) begin
                    Flush = 1'b1;
                    next_cycle();
                    Flush     = 1'b0;
                    cancelled = 1'b1;
                end else begin
                    repeat (gap) next_cycle();
                    MemDataReady = 1'b1;
                    MemDataIn    = mem_word(MemReadAddress + 32'(4 * b));
                    Mispredict   = (cancel_kind == CANCEL_MISPREDICT && b == cancel_beat);
                    next_cycle();
                    cancelled    = Mispredict;
                    MemDataReady = 1'b0;
                    Mispredict   = 1'b0;
                    MemDataIn    = '0;
                end
            end
            if (cancelled) begin
                if (MemReadRequest !== 1'b0) begin
                    report_mismatch("MemReadRequest", 32'h0, {31'b0, MemReadRequest});
                end
                if (Busy !== 1'b0) begin
                    report_mismatch("Busy", 32'h0, {31'b0, Busy});
                end
            end else begin
                if (Ready !== 1'b1) begin
                    report_mismatch("Ready", 32'h1, {31'b0, Ready});
                end
                if (!exp_hit) begin
                    ref_fill(addr);
                end
            end
        end else if (Ready !== 1'b1) begin
            report_mismatch("Ready", 32'h1, {31'b0, Ready});
        end
        ReadEnable = 1'b0;
        next_cycle();
    endtask

    // Every Ready must carry the oldest outstanding expected word
    initial begin
        logic [31:0] exp_word;
        forever begin
            @(negedge Clk);
            if (Ready === 1'b1) begin
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("Ready asserted with no fetch outstanding at %0t", $time);
                end else begin
                    exp_word = expected_q.pop_front();
                    if (Instruction !== exp_word) begin
                        report_mismatch("Instruction", exp_word, Instruction);
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        int          kind;
        int          beat;
        arst_n       = 1'b0;
        ReadEnable   = 1'b0;
        ReadAddress  = '0;
        MemDataIn    = '0;
        MemDataReady = 1'b0;
        Mispredict   = 1'b0;
        Flush        = 1'b0;
        lfsr_q       = 32'h058c1f77;
        error_count  = 0;
        fetch_count  = 0;
        for (int s = 0; s < icache_geom_pkg::NUM_SETS; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end

        repeat (2) @(posedge Clk);
        #1;
        arst_n = 1'b1;
        next_cycle();

        // Cold miss, then hits in the same block
        run_fetch(32'h0000_0108, CANCEL_NONE, 0);
        run_fetch(32'h0000_010c, CANCEL_NONE, 0);
        run_fetch(32'h0000_0100, CANCEL_NONE, 0);

        // Five blocks in one set, then re-reads across the evictions
        for (int i = 0; i < 5; i++) begin
            run_fetch(32'h1000_0020 + 32'(i * SET_STRIDE), CANCEL_NONE, 0);
        end
        for (int i = 0; i < 8; i++) begin
            run_fetch(32'h1000_0024 + 32'(reread_order[i] * SET_STRIDE), CANCEL_NONE, 0);
        end

        // Cancelled refills leave the block absent
        run_fetch(32'h0000_2214, CANCEL_FLUSH, 2);
        run_fetch(32'h0000_2214, CANCEL_NONE, 0);
        run_fetch(32'h0000_3304, CANCEL_MISPREDICT, 1);
        run_fetch(32'h0000_3304, CANCEL_NONE, 0);

        // Random traffic over a small footprint so that hits occur
        for (int i = 0; i < NUM_RANDOM; i++) begin
            addr = 32'h0004_0000 | (take_bits(9) << 2);
            kind = CANCEL_NONE;
            beat = 0;
            if (take_bits(4) == 0) begin
                kind = (take_bits(1) != 0) ? CANCEL_FLUSH : CANCEL_MISPREDICT;
                beat = int'(take_bits(icache_geom_pkg::WOFS_W));
            end
            run_fetch(addr, kind, beat);
        end

        repeat (4) next_cycle();
        if (expected_q.size() != 0) begin
            error_count++;
            $display("%0d fetches never returned Ready", expected_q.size());
        end
        $display("Summary: %0d fetches, %0d check errors, %0d assertion failures",
                 fetch_count, error_count, UUT.u_assertions.fail_count);
        if (error_count == 0 && UUT.u_assertions.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
